/* rtl/mono_tint_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths, coefficients, tint modes and pixel structs
// for the monochrome tint pipeline, imported by every block
////////////////////////////////////////////////////////////

package mono_tint_pkg;

	// Channel widths in and out
	localparam int chan_w = 6;
	localparam int out_w = 8;

	// Zero low bits appended to each output channel
	localparam int pad_w = out_w - chan_w;

	// Red, green, blue
	localparam int num_chan = 3;

	////////////////////////////////////////////////////////////
	// Luminance weights
	////////////////////////////////////////////////////////////

	// Coefficient scale is 1/256
	localparam int coef_w = 8;

	// Index 0 red, 1 green, 2 blue
	localparam logic [coef_w-1:0] chan_coef [num_chan] = '{8'd54, 8'd183, 8'd18};

	// Monitor emulation modes
	typedef enum logic [1:0] {
		tint_color,
		tint_green,
		tint_amber,
		tint_mono
	} tint_mode_t;

	////////////////////////////////////////////////////////////
	// Pixel and lane payloads
	////////////////////////////////////////////////////////////

	typedef logic [chan_w-1:0] chan_t;

	// Incoming 6 bit per channel pixel
	typedef struct packed {
		chan_t red;
		chan_t green;
		chan_t blue;
	} rgb_in_t;

	// Widened output pixel
	typedef struct packed {
		logic [out_w-1:0] red;
		logic [out_w-1:0] green;
		logic [out_w-1:0] blue;
	} rgb_out_t;

	// Raw channel plus its weighted share of luminance
	typedef struct packed {
		chan_t raw;
		chan_t weight;
	} lane_beat_t;

endpackage

/* rtl/pixel_intake.sv */
////////////////////////////////////////////////////////////
// Four-phase pixel receiver with a single holding register,
// hands the held pixel to the weighting lanes channel by channel
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pixel_intake (
	input  logic                                           CLK_50M,
	input  logic                                           reset,

	// Four-phase input side
	input  logic                                           in_req,
	input  mono_tint_pkg::rgb_in_t                         in_pixel,
	output logic                                           in_ack,

	// Lane side
	input  logic                                           lane_take,
	output logic                                           lane_load,
	output mono_tint_pkg::chan_t [mono_tint_pkg::num_chan-1:0] lane_chan
);

	import mono_tint_pkg::*;

	// Holding register and its valid bit
	logic    held;
	rgb_in_t held_pixel;

	// New request, previous handshake closed, register free
	logic    capture;

	assign capture = in_req && !in_ack && !held;

	////////////////////////////////////////////////////////////
	// Handshake and valid control
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			held   <= 1'b0;
			in_ack <= 1'b0;
		end else begin
			// Capture only when empty, so set and release never collide
			if (capture) begin
				held <= 1'b1;
			end else if (lane_take) begin
				held <= 1'b0;
			end

			// Ack follows the capture, drops once req is gone
			if (capture) begin
				in_ack <= 1'b1;
			end else if (!in_req) begin
				in_ack <= 1'b0;
			end
		end
	end

	// Pixel payload
	always_ff @(posedge CLK_50M) begin
		if (capture) begin
			held_pixel <= in_pixel;
		end
	end

	// Offer the pixel while holding
	assign lane_load = held;

	// Split into lanes, red 0, green 1, blue 2
	assign lane_chan[0] = held_pixel.red;
	assign lane_chan[1] = held_pixel.green;
	assign lane_chan[2] = held_pixel.blue;

endmodule

/* rtl/luma_lane.sv */
////////////////////////////////////////////////////////////
// One colour channel weighting stage, instanced per channel
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module luma_lane #(
	// Luminance coefficient for this channel, scaled by 256
	parameter logic [mono_tint_pkg::coef_w-1:0] coef = '0
) (
	input  logic                      CLK_50M,
	input  logic                      reset,

	// Beat offered by the intake
	input  logic                      lane_load,
	input  mono_tint_pkg::chan_t      chan_in,

	// Advance strobe from the mixer
	input  logic                      lane_take,

	output logic                      lane_full,
	output mono_tint_pkg::lane_beat_t beat
);

	import mono_tint_pkg::*;

	// Full precision product of value and coefficient
	logic [chan_w+coef_w-1:0] product;

	assign product = chan_in * coef;

	////////////////////////////////////////////////////////////
	// Lane register
	////////////////////////////////////////////////////////////

	// Full tracks whether a beat came in on the last advance
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			lane_full <= 1'b0;
		end else if (lane_take) begin
			lane_full <= lane_load;
		end
	end

	// Raw value kept for colour and MDA bypass
	// Upper bits of the product give value * coef / 256, rounded down
	always_ff @(posedge CLK_50M) begin
		if (lane_take && lane_load) begin
			beat.raw    <= chan_in;
			beat.weight <= product[chan_w+coef_w-1:coef_w];
		end
	end

endmodule

/* rtl/tint_mixer.sv */
////////////////////////////////////////////////////////////
// Sums lane weights into luminance, applies tint or bypass,
// and drives the four-phase output and the lane advance strobe
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tint_mixer (
	input  logic                                                   CLK_50M,
	input  logic                                                   reset,

	// Static configuration
	input  mono_tint_pkg::tint_mode_t                              tint_mode,
	input  logic                                                   mda_mode,

	// Lane side
	input  logic [mono_tint_pkg::num_chan-1:0]                     lane_full,
	input  mono_tint_pkg::lane_beat_t [mono_tint_pkg::num_chan-1:0] beats,
	output logic                                                   lane_take,

	// Four-phase output side
	input  logic                                                   out_ack,
	output logic                                                   out_req,
	output mono_tint_pkg::rgb_out_t                                out_pixel
);

	import mono_tint_pkg::*;

	// Lane and slot status
	logic  lanes_full;
	logic  slot_busy;
	logic  take_beat;

	// Luminance and its half for amber
	chan_t luma;
	chan_t luma_half;

	// Tinted channels before padding
	chan_t mix_red;
	chan_t mix_green;
	chan_t mix_blue;

	////////////////////////////////////////////////////////////
	// Advance decision
	////////////////////////////////////////////////////////////

	// Lanes always move together
	assign lanes_full = &lane_full;

	// Slot stays busy until the sink drops ack
	assign slot_busy = out_req || out_ack;

	// Beat moves into the output slot
	assign take_beat = lanes_full && !slot_busy;

	// Lanes advance when empty or when their beat moves on
	assign lane_take = !lanes_full || take_beat;

	////////////////////////////////////////////////////////////
	// Luminance and tint
	////////////////////////////////////////////////////////////

	// Weights sum to at most 62, fits a channel
	always_comb begin
		luma = '0;
		for (int i = 0; i < num_chan; i++) begin
			luma = luma + beats[i].weight;
		end
	end

	assign luma_half = luma >> 1;

	always_comb begin
		// MDA output never gets tinted
		if (mda_mode || tint_mode == tint_color) begin
			mix_red   = beats[0].raw;
			mix_green = beats[1].raw;
			mix_blue  = beats[2].raw;
		end else begin
			case (tint_mode)
				tint_green: begin
					mix_red   = '0;
					mix_green = luma;
					mix_blue  = '0;
				end
				tint_amber: begin
					mix_red   = luma;
					mix_green = luma_half;
					mix_blue  = '0;
				end
				default: begin
					// White phosphor
					mix_red   = luma;
					mix_green = luma;
					mix_blue  = luma;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Output slot
	////////////////////////////////////////////////////////////

	// Req rises with the registered pixel, falls on ack
	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			out_req <= 1'b0;
		end else if (take_beat) begin
			out_req <= 1'b1;
		end else if (out_ack) begin
			out_req <= 1'b0;
		end
	end

	// Widen with zero low bits
	always_ff @(posedge CLK_50M) begin
		if (take_beat) begin
			out_pixel.red   <= {mix_red, {pad_w{1'b0}}};
			out_pixel.green <= {mix_green, {pad_w{1'b0}}};
			out_pixel.blue  <= {mix_blue, {pad_w{1'b0}}};
		end
	end

endmodule

/* rtl/mono_tint_top.sv */
////////////////////////////////////////////////////////////
// Monochrome monitor emulation top, intake to lanes to mixer
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mono_tint_top (
	input  logic                      CLK_50M,
	input  logic                      reset,

	// Static configuration
	input  mono_tint_pkg::tint_mode_t tint_mode,
	input  logic                      mda_mode,

	// Four-phase pixel input
	input  logic                      in_req,
	input  mono_tint_pkg::rgb_in_t    in_pixel,
	output logic                      in_ack,

	// Four-phase pixel output
	input  logic                      out_ack,
	output logic                      out_req,
	output mono_tint_pkg::rgb_out_t   out_pixel
);

	import mono_tint_pkg::*;

	// Intake to lanes
	logic                      lane_load;
	chan_t      [num_chan-1:0] lane_chan;

	// Lanes to mixer
	logic       [num_chan-1:0] lane_full;
	lane_beat_t [num_chan-1:0] beats;

	// Single advance strobe, owned by the mixer
	logic                      lane_take;

	pixel_intake i_intake (
		.CLK_50M   (CLK_50M),
		.reset     (reset),
		.in_req    (in_req),
		.in_pixel  (in_pixel),
		.in_ack    (in_ack),
		.lane_take (lane_take),
		.lane_load (lane_load),
		.lane_chan (lane_chan)
	);

	////////////////////////////////////////////////////////////
	// Weighting lanes, one per colour channel
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < num_chan; i++) begin : g_lane
		// Coefficient picked by channel index
		luma_lane #(
			.coef (chan_coef[i])
		) i_lane (
			.CLK_50M   (CLK_50M),
			.reset     (reset),
			.lane_load (lane_load),
			.chan_in   (lane_chan[i]),
			.lane_take (lane_take),
			.lane_full (lane_full[i]),
			.beat      (beats[i])
		);
	end

	tint_mixer i_mixer (
		.CLK_50M   (CLK_50M),
		.reset     (reset),
		.tint_mode (tint_mode),
		.mda_mode  (mda_mode),
		.lane_full (lane_full),
		.beats     (beats),
		.lane_take (lane_take),
		.out_ack   (out_ack),
		.out_req   (out_req),
		.out_pixel (out_pixel)
	);

endmodule

/* test/mono_tint_checker.sv */
////////////////////////////////////////////////////////////
// Bound checker that models expected pixels in capture order
// and watches both four-phase handshakes of the tint pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mono_tint_checker (
	input logic                      CLK_50M,
	input logic                      reset,
	input mono_tint_pkg::tint_mode_t tint_mode,
	input logic                      mda_mode,
	input logic                      in_req,
	input logic                      in_ack,
	input mono_tint_pkg::rgb_in_t    in_pixel,
	input logic                      out_req,
	input logic                      out_ack,
	input mono_tint_pkg::rgb_out_t   out_pixel
);

	import mono_tint_pkg::*;

	// Circular buffer of expected pixels in capture order
	rgb_out_t   exp_mem [8];
	logic [2:0] wr_ptr;
	logic [2:0] rd_ptr;
	logic       in_ack_q;
	logic       out_req_q;

	// One sticky failure bit per assertion
	logic idle_bad;
	logic ack_bad;
	logic hold_bad;
	logic out_bad;
	logic new_bad;
	logic spur_bad;
	logic data_bad;
	logic failed;

	initial begin
		idle_bad = 1'b0;
		ack_bad  = 1'b0;
		hold_bad = 1'b0;
		out_bad  = 1'b0;
		new_bad  = 1'b0;
		spur_bad = 1'b0;
		data_bad = 1'b0;
	end

	assign failed = idle_bad | ack_bad | hold_bad | out_bad | new_bad | spur_bad | data_bad;

	// Weight per channel is value * coefficient / 256 rounded down
	function automatic rgb_out_t expect_pixel(input rgb_in_t p, input tint_mode_t mode,
		input logic mda);
		int       luma;
		rgb_out_t e;
		luma = (int'(p.red) * 54) / 256 + (int'(p.green) * 183) / 256
			+ (int'(p.blue) * 18) / 256;
		e = '0;
		if (mda || mode == tint_color) begin
			e.red   = {p.red, 2'b00};
			e.green = {p.green, 2'b00};
			e.blue  = {p.blue, 2'b00};
		end else if (mode == tint_green) begin
			e.green = 8'(luma * 4);
		end else if (mode == tint_amber) begin
			e.red   = 8'(luma * 4);
			e.green = 8'((luma / 2) * 4);
		end else begin
			e.red   = 8'(luma * 4);
			e.green = 8'(luma * 4);
			e.blue  = 8'(luma * 4);
		end
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			in_ack_q  <= 1'b0;
			out_req_q <= 1'b0;
		end else begin
			in_ack_q  <= in_ack;
			out_req_q <= out_req;
			// Ack rise marks a capture while the source still holds the pixel
			if (in_ack && !in_ack_q) begin
				exp_mem[wr_ptr] <= expect_pixel(in_pixel, tint_mode, mda_mode);
				wr_ptr          <= wr_ptr + 3'd1;
			end
			// Each req rise consumes one expected pixel
			if (out_req && !out_req_q) begin
				rd_ptr <= rd_ptr + 3'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Assertions
	////////////////////////////////////////////////////////////

	a_reset_idle: assert property (@(posedge CLK_50M) reset |=> !in_ack && !out_req)
		else begin
			idle_bad = 1'b1;
			$error("in_ack or out_req was high right after reset");
		end

	a_ack_after_req: assert property (@(posedge CLK_50M) disable iff (reset)
		$rose(in_ack) |-> $past(in_req))
		else begin
			ack_bad = 1'b1;
			$error("in_ack rose without a request");
		end

	a_ack_hold: assert property (@(posedge CLK_50M) disable iff (reset)
		in_req && in_ack |=> in_ack)
		else begin
			hold_bad = 1'b1;
			$error("in_ack dropped while in_req was still high");
		end

	// Output req and pixel hold until the sink acks
	a_out_hold: assert property (@(posedge CLK_50M) disable iff (reset)
		out_req && !out_ack |=> out_req && $stable(out_pixel))
		else begin
			out_bad = 1'b1;
			$error("out_req or out_pixel changed before out_ack");
		end

	// Req is registered on the edge before it is seen high
	a_out_new: assert property (@(posedge CLK_50M) disable iff (reset)
		$rose(out_req) |-> !$past(out_ack))
		else begin
			new_bad = 1'b1;
			$error("out_req rose while out_ack was still high");
		end

	a_no_spurious: assert property (@(posedge CLK_50M) disable iff (reset)
		$rose(out_req) |-> rd_ptr != wr_ptr)
		else begin
			spur_bad = 1'b1;
			$error("out_req rose with no accepted input pixel pending");
		end

	a_data: assert property (@(posedge CLK_50M) disable iff (reset)
		$rose(out_req) && rd_ptr != wr_ptr |-> out_pixel == exp_mem[rd_ptr])
		else begin
			data_bad = 1'b1;
			$error("Fail %0t out_pixel expected %h actual %h", $time, exp_mem[rd_ptr],
				out_pixel);
		end

endmodule

bind mono_tint_top mono_tint_checker i_checker (
	.CLK_50M   (CLK_50M),
	.reset     (reset),
	.tint_mode (tint_mode),
	.mda_mode  (mda_mode),
	.in_req    (in_req),
	.in_ack    (in_ack),
	.in_pixel  (in_pixel),
	.out_req   (out_req),
	.out_ack   (out_ack),
	.out_pixel (out_pixel)
);

/* test/tb_mono_tint.sv */
////////////////////////////////////////////////////////////
// Random pixels through every tint mode and MDA bypass
// into a randomly stalling output sink
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_mono_tint;

	import mono_tint_pkg::*;

	localparam int seg_len    = 24;
	localparam int wait_limit = 50;
	localparam int drive_dly  = 2;

	logic       CLK_50M;
	logic       reset;
	tint_mode_t tint_mode;
	logic       mda_mode;
	logic       in_req;
	logic       in_ack;
	rgb_in_t    in_pixel;
	logic       out_req;
	logic       out_ack;
	rgb_out_t   out_pixel;

	// Per segment stimulus drawn before driver and sink start
	rgb_in_t     stim_pixel [seg_len];
	int          stim_delay [seg_len];
	int          req_hold [seg_len];
	int          ack_hold [seg_len];
	int          sent_count;
	int          taken_count;
	logic [31:0] lfsr_state;

	mono_tint_top i_dut (
		.CLK_50M   (CLK_50M),
		.reset     (reset),
		.tint_mode (tint_mode),
		.mda_mode  (mda_mode),
		.in_req    (in_req),
		.in_pixel  (in_pixel),
		.in_ack    (in_ack),
		.out_ack   (out_ack),
		.out_req   (out_req),
		.out_pixel (out_pixel)
	);

	// 50 MHz
	always #10 CLK_50M = ~CLK_50M;

	task automatic report_failure(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	// Stop at the first failing assertion in the bound checker
	always @(posedge CLK_50M) begin
		if (i_dut.i_checker.failed === 1'b1) begin
			report_failure("an assertion in the bound checker failed");
		end
	end

	////////////////////////////////////////////////////////////
	// Random source and timing helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit
	function automatic logic next_rand_bit();
		logic lsb;
		lsb        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 32'h80200003;
		end
		return lsb;
	endfunction

	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], next_rand_bit()};
		end
		return bits;
	endfunction

	// Inputs change a little after the edge
	task automatic next_cycle();
		@(posedge CLK_50M);
		#drive_dly;
	endtask

	task automatic tick_timeout(inout int waited, input string what);
		waited++;
		if (waited > wait_limit) begin
			report_failure({"timeout while waiting for ", what});
		end
	endtask

	task automatic fill_stimulus();
		logic [17:0] raw;
		for (int k = 0; k < seg_len; k++) begin
			raw           = 18'(rand_bits(18));
			stim_pixel[k] = raw;
			stim_delay[k] = int'(rand_bits(2));
			req_hold[k]   = int'(rand_bits(2));
			ack_hold[k]   = int'(rand_bits(2));
		end
		// Full scale first for the largest luminance
		stim_pixel[0] = '1;
	endtask

	////////////////////////////////////////////////////////////
	// Four-phase driver and sink
	////////////////////////////////////////////////////////////

	task automatic send_pixels();
		int waited;
		for (int k = 0; k < seg_len; k++) begin
			// No new req until the previous ack is gone
			waited = 0;
			while (in_ack) begin
				next_cycle();
				tick_timeout(waited, "in_ack to fall");
			end
			in_pixel = stim_pixel[k];
			in_req   = 1'b1;
			waited   = 0;
			do begin
				next_cycle();
				tick_timeout(waited, "in_ack to rise");
			end while (!in_ack);
			// Source keeps req up for 0 to 3 cycles after the ack
			repeat (req_hold[k]) next_cycle();
			in_req = 1'b0;
			sent_count++;
		end
	endtask

	task automatic take_pixels();
		int waited;
		for (int k = 0; k < seg_len; k++) begin
			waited = 0;
			while (!out_req) begin
				next_cycle();
				tick_timeout(waited, "out_req to rise");
			end
			// Sink stall of 0 to 3 cycles
			repeat (stim_delay[k]) next_cycle();
			out_ack = 1'b1;
			waited  = 0;
			do begin
				next_cycle();
				tick_timeout(waited, "out_req to fall");
			end while (out_req);
			// Sink keeps ack up for 0 to 3 cycles after req falls
			repeat (ack_hold[k]) next_cycle();
			out_ack = 1'b0;
			taken_count++;
		end
	endtask

	// Config changes only with the pipeline drained
	task automatic run_segment(input tint_mode_t mode, input logic mda);
		next_cycle();
		tint_mode = mode;
		mda_mode  = mda;
		fill_stimulus();
		fork
			send_pixels();
			take_pixels();
		join
	endtask

	initial begin
		CLK_50M     = 1'b0;
		reset       = 1'b1;
		tint_mode   = tint_color;
		mda_mode    = 1'b0;
		in_req      = 1'b0;
		in_pixel    = '0;
		out_ack     = 1'b0;
		sent_count  = 0;
		taken_count = 0;
		lfsr_state  = 32'h2750e000;
		repeat (4) @(posedge CLK_50M);
		#drive_dly;
		reset = 1'b0;
		// Idle after reset with nothing in flight
		repeat (5) next_cycle();
		run_segment(tint_color, 1'b0);
		run_segment(tint_color, 1'b1);
		run_segment(tint_green, 1'b1);
		run_segment(tint_amber, 1'b1);
		run_segment(tint_mono, 1'b1);
		run_segment(tint_green, 1'b0);
		run_segment(tint_amber, 1'b0);
		run_segment(tint_mono, 1'b0);
		repeat (5) next_cycle();
		if (sent_count != taken_count || i_dut.i_checker.failed !== 1'b0) begin
			report_failure("pixel counts differ or the checker flagged an error");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

/* files.f */
rtl/mono_tint_pkg.sv
rtl/pixel_intake.sv
rtl/luma_lane.sv
rtl/tint_mixer.sv
rtl/mono_tint_top.sv
test/mono_tint_checker.sv
test/tb_mono_tint.sv

/* Makefile */
# Verilator build and run for the tint pipeline testbench

VERILATOR := verilator
TOP       := tb_mono_tint
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timescale 1ns/10ps -j 0 --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+100

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
